// ==== bench/firBench.sv ====
`timescale 1ns/1ps

module firBench;
    import firPkg::*;

    localparam int numTaps = 32;
    localparam int osr = 8;
    localparam int lutWidth = 4;
    // Frame capture and lookup, then one register per tree level
    localparam int latency = 2 + $clog2(numTaps / lutWidth);
    localparam int startLimit = 5000;
    localparam int drainLimit = 200;
    localparam int doneLimit = drainLimit + 100;

    logic      clkDS;
    logic      rst;
    logic      sampleStrobe;
    logic      sampleBit;
    logic      cfgStrobe;
    coefWriteT cfgWrite;
    logic      outStrobe;
    sumT       outValue;
    logic      stimDone;
    logic      checkDone;
    int        valueErrors;
    int        otherErrors;
    int        benchErrors;
    int        seed;

    firDecimator #(
        .numTaps(numTaps),
        .osr(osr),
        .lutWidth(lutWidth)
    ) DUT (
        .clkDS(clkDS),
        .rst(rst),
        .sampleStrobe(sampleStrobe),
        .sampleBit(sampleBit),
        .cfgStrobe(cfgStrobe),
        .cfgWrite(cfgWrite),
        .outStrobe(outStrobe),
        .outValue(outValue)
    );

    firChecker #(
        .osr(osr),
        .latency(latency),
        .startLimit(startLimit),
        .drainLimit(drainLimit)
    ) uChecker (
        .clkDS(clkDS),
        .rst(rst),
        .sampleStrobe(sampleStrobe),
        .outStrobe(outStrobe),
        .outValue(outValue),
        .stimDone(stimDone),
        .checkDone(checkDone),
        .valueErrors(valueErrors),
        .otherErrors(otherErrors)
    );

    initial begin
        clkDS = 1'b0;
        forever #10 clkDS = ~clkDS;
    end

    // Drive point 1 ns past the rising edge with strobes idle by default
    task automatic nextCycle();
        @(posedge clkDS);
        #1;
        sampleStrobe = 1'b0;
        cfgStrobe = 1'b0;
    endtask

    task automatic idleCycles(input int count);
        for (int i = 0; i < count; i++) begin
            nextCycle();
        end
    endtask

    task automatic writeCoef(input int addr, input int value);
        nextCycle();
        cfgStrobe = 1'b1;
        cfgWrite.addr = addr[tapAddrWidth-1:0];
        cfgWrite.value = value[coefWidth-1:0];
    endtask

    // LSB goes out first
    task automatic sendBits(input int count, input logic [31:0] bits, input bit randomGaps);
        int gap;
        for (int i = 0; i < count; i++) begin
            nextCycle();
            sampleStrobe = 1'b1;
            sampleBit = bits[i];
            if (randomGaps) begin
                gap = $unsigned($random(seed)) % 4;
                idleCycles(gap);
            end
        end
    endtask

    initial begin
        int    fd;
        int    rc;
        int    argA;
        int    argB;
        int    waited;
        string line;
        byte   kind;
        seed = 32'h5f99;
        rst = 1'b0;
        sampleStrobe = 1'b0;
        sampleBit = 1'b0;
        cfgStrobe = 1'b0;
        cfgWrite = '0;
        stimDone = 1'b0;
        benchErrors = 0;
        repeat (5) @(posedge clkDS);
        #1;
        rst = 1'b1;

        fd = $fopen("bench/firPatterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/firPatterns.txt for stimulus");
            benchErrors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (line.len() > 2 && line.getc(0) != "#" && line.getc(0) != "E") begin
                    kind = line.getc(0);
                    argA = 0;
                    argB = 0;
                    rc = $sscanf(line.substr(2, line.len() - 1), "%h %h", argA, argB);
                    case (kind)
                        "C": writeCoef(argA, argB);
                        "S": sendBits(argA, argB, 1'b0);
                        "R": sendBits(argA, argB, 1'b1);
                        "G": idleCycles(argA);
                        default: begin
                            $display("unknown stimulus record: %0s", line);
                            benchErrors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        nextCycle();
        stimDone = 1'b1;

        waited = 0;
        while (!checkDone && waited < doneLimit) begin
            @(posedge clkDS);
            waited++;
        end
        if (!checkDone) begin
            $display("timeout: checker still busy %0d cycles after the stimulus ended",
                     doneLimit);
            $display("errors: value %0d, other %0d", valueErrors,
                     otherErrors + benchErrors + 1);
            $display("Result: FAILED");
        end else begin
            $display("errors: value %0d, other %0d", valueErrors, otherErrors + benchErrors);
            if (valueErrors == 0 && otherErrors == 0 && benchErrors == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
        end
        $finish;
    end

endmodule

// ==== bench/firChecker.sv ====
`timescale 1ns/1ps

module firChecker #(
    parameter int osr = 8,
    parameter int latency = 5,
    parameter int startLimit = 5000,
    parameter int drainLimit = 200
) (
    input  logic        clkDS,
    input  logic        rst,
    input  logic        sampleStrobe,
    input  logic        outStrobe,
    input  firPkg::sumT outValue,
    input  logic        stimDone,
    output logic        checkDone,
    output int          valueErrors,
    output int          otherErrors
);
    import firPkg::*;

    logic [8*16-1:0] expNames [$];
    sumT             expValues [$];
    int              dueCycles [$];

    int              cycle = 0;
    int              strobeCount = 0;
    int              mismatches = 0;
    int              lateErrors = 0;
    int              fileErrors;
    int              drainErrors;
    int              dropped;
    logic [8*16-1:0] headName;
    sumT             headValue;

    assign valueErrors = mismatches;
    assign otherErrors = lateErrors + fileErrors + drainErrors;

    // Expected words come from the E records only
    initial begin
        int              fd;
        int              rc;
        int              waited;
        string           line;
        logic [8*16-1:0] name;
        sumT             value;
        fileErrors = 0;
        drainErrors = 0;
        checkDone = 1'b0;
        fd = $fopen("bench/firPatterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/firPatterns.txt for expected values");
            fileErrors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (line.len() > 2 && line.getc(0) == "E") begin
                    rc = $sscanf(line.substr(2, line.len() - 1), "%s %h", name, value);
                    if (rc == 2) begin
                        expNames.push_back(name);
                        expValues.push_back(value);
                    end else begin
                        $display("malformed expected record: %0s", line);
                        fileErrors++;
                    end
                end
            end
            $fclose(fd);
        end
        if (expValues.size() == 0) begin
            $display("no expected values found in the patterns file");
            fileErrors++;
        end

        waited = 0;
        while (!stimDone && waited < startLimit) begin
            @(posedge clkDS);
            waited++;
        end
        if (!stimDone) begin
            $display("timeout: stimulus still running after %0d cycles", startLimit);
            drainErrors++;
        end

        waited = 0;
        while ((expValues.size() > 0 || dueCycles.size() > 0) && waited < drainLimit) begin
            @(posedge clkDS);
            waited++;
        end
        if (expValues.size() > 0) begin
            $display("timeout: %0d expected values still pending, next is test %0s",
                     expValues.size(), expNames[0]);
            drainErrors++;
        end
        if (dueCycles.size() > 0) begin
            $display("timeout: %0d frames never produced an output", dueCycles.size());
            drainErrors++;
        end
        checkDone = 1'b1;
    end

    // Sampled mid-cycle between the edges that move DUT signals
    always @(negedge clkDS) begin
        cycle++;
        if (rst) begin
            if (dueCycles.size() > 0 && dueCycles[0] == cycle) begin
                dropped = dueCycles.pop_front();
                if (!outStrobe) begin
                    $display("no outStrobe at cycle %0d, %0d cycles after a completed frame",
                             cycle, latency);
                    lateErrors++;
                end
            end else if (outStrobe) begin
                $display("outStrobe at cycle %0d without a frame completed %0d cycles before",
                         cycle, latency);
                lateErrors++;
            end

            if (outStrobe) begin
                if (expValues.size() == 0) begin
                    $display("outStrobe at cycle %0d with no expected value left", cycle);
                    lateErrors++;
                end else begin
                    headName = expNames.pop_front();
                    headValue = expValues.pop_front();
                    if (outValue !== headValue) begin
                        $display("error: test %0s expected %0d actual %0d",
                                 headName, headValue, outValue);
                        mismatches++;
                    end
                end
            end

            // Every osr-th strobe completes a frame
            if (sampleStrobe) begin
                strobeCount++;
                if (strobeCount == osr) begin
                    strobeCount = 0;
                    dueCycles.push_back(cycle + latency);
                end
            end
        end
    end

endmodule

// ==== bench/firPatterns.txt ====
# C addr value: coefficient write. S count bits: bits sent LSB first. R: same with random gaps
# G count: idle cycles. E name value: next expected output. All numbers are hex
G 14
C 00 064
C 03 07B
C 07 010
C 0B F38
C 0F FFF
C 13 1F4
C 17 7FF
C 1B 831
C 1F 800
S 10 00000000
E zeros 00000
E zeros 00000
S 20 00000001
S 8 00000000
E impulse7 00010
E impulse7 FFFFF
E impulse7 007FF
E impulse7 FF800
E impulse7 00000
R 20 00000010
R 8 00000000
E impulse3 0007B
E impulse3 FFF38
E impulse3 001F4
E impulse3 FF831
E impulse3 00000
S 20 FFFFFFFF
S 8 000000FF
E allOnes 000EF
E allOnes 00026
E allOnes 00A19
E allOnes FFA4A
E allOnes FFA4A
C 0B 12C
S 8 000000FF
E rewrite FFC3E
S 10 0000FFEF
E rewriteBit3 FFBC3
E rewriteBit11 FFB12

// ==== project.f ====
source/firPkg.sv
source/coefBank.sv
source/sampleWindow.sv
source/partialSumLut.sv
source/adderTree.sv
source/firDecimator.sv
bench/firChecker.sv
bench/firBench.sv

// ==== run.sh ====
#!/bin/sh
# Build the FIR decimator testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module firBench \
    -Mdir "$buildDir"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$("./$buildDir/VfirBench" 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== source/adderTree.sv ====
`timescale 1ns/1ps

module adderTree #(
    parameter int numInputs = 8
) (
    input  logic        clkDS,
    input  logic        rst,
    input  logic        inValid,
    input  firPkg::sumT partials [numInputs],
    output firPkg::sumT result,
    output logic        resultValid
);
    import firPkg::*;

    localparam int treeDepth = (numInputs > 1) ? $clog2(numInputs) : 0;

    // Number of nodes left after a given level
    function automatic int levelCount(int level);
        int n;
        n = numInputs;
        for (int l = 0; l < level; l++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    // Level 0 holds the inputs, level treeDepth the final sum
    logic [treeDepth:0][numInputs-1:0][sumWidth-1:0] stage;
    logic [treeDepth:0] validPipe;

    for (genvar i = 0; i < numInputs; i++) begin : gLeaf
        assign stage[0][i] = partials[i];
    end

    assign validPipe[0] = inValid;

    for (genvar l = 0; l < treeDepth; l++) begin : gLevel
        localparam int inCount = levelCount(l);
        localparam int outCount = levelCount(l + 1);

        for (genvar i = 0; i < outCount; i++) begin : gNode
            if (2 * i + 1 < inCount) begin : gAdd
                always_ff @(posedge clkDS) begin
                    stage[l+1][i] <= stage[l][2*i] + stage[l][2*i+1];
                end
            end else begin : gPass
                // Odd leftover waits one register
                always_ff @(posedge clkDS) begin
                    stage[l+1][i] <= stage[l][2*i];
                end
            end
        end

        always_ff @(posedge clkDS) begin
            if (!rst) begin
                validPipe[l+1] <= 1'b0;
            end else begin
                validPipe[l+1] <= validPipe[l];
            end
        end
    end

    assign result = sumT'(stage[treeDepth][0]);
    assign resultValid = validPipe[treeDepth];

    // Every emitted frame carries a fully known sum
    knownResult: assert property (
        @(posedge clkDS) disable iff (!rst)
        resultValid |-> !$isunknown(result)
    ) else $error("adderTree: unknown result while resultValid is high");

endmodule

// ==== source/coefBank.sv ====
`timescale 1ns/1ps

module coefBank #(
    parameter int numTaps = 32
) (
    input  logic             clkDS,
    input  logic             rst,
    input  logic             cfgStrobe,
    input  firPkg::coefWriteT cfgWrite,
    output firPkg::coefT     coefs [numTaps]
);
    import firPkg::*;

    // One register per tap written one at a time
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            for (int k = 0; k < numTaps; k++) begin
                coefs[k] <= '0;
            end
        end else if (cfgStrobe) begin
            for (int k = 0; k < numTaps; k++) begin
                if (cfgWrite.addr == tapAddrWidth'(k)) begin
                    coefs[k] <= cfgWrite.value;
                end
            end
        end
    end

    // Writes past the window are dropped by the loop above
    addrInRange: assert property (
        @(posedge clkDS) disable iff (!rst)
        cfgStrobe |-> (int'(cfgWrite.addr) < numTaps)
    ) else $error("coefBank: write to tap %0d, only %0d taps", cfgWrite.addr, numTaps);

endmodule

// ==== source/firDecimator.sv ====
`timescale 1ns/1ps

module firDecimator #(
    parameter int numTaps = 32,
    parameter int osr = 8,
    parameter int lutWidth = 4
) (
    input  logic              clkDS,
    input  logic              rst,
    input  logic              sampleStrobe,
    input  logic              sampleBit,
    input  logic              cfgStrobe,
    input  firPkg::coefWriteT cfgWrite,
    output logic              outStrobe,
    output firPkg::sumT       outValue
);
    import firPkg::*;

    localparam int numLuts = numTaps / lutWidth;

    logic               frameStrobe;
    logic [numTaps-1:0] window;
    coefT               coefs [numTaps];
    sumT                lutSums [numLuts];
    logic               lutValid;

    coefBank #(
        .numTaps(numTaps)
    ) uCoefBank (
        .clkDS(clkDS),
        .rst(rst),
        .cfgStrobe(cfgStrobe),
        .cfgWrite(cfgWrite),
        .coefs(coefs)
    );

    sampleWindow #(
        .numTaps(numTaps),
        .osr(osr)
    ) uSampleWindow (
        .clkDS(clkDS),
        .rst(rst),
        .sampleStrobe(sampleStrobe),
        .sampleBit(sampleBit),
        .frameStrobe(frameStrobe),
        .window(window)
    );

    // Lookup g covers taps g*lutWidth up to g*lutWidth+lutWidth-1
    for (genvar g = 0; g < numLuts; g++) begin : gLut
        coefT groupCoefs [lutWidth];

        for (genvar k = 0; k < lutWidth; k++) begin : gCoef
            assign groupCoefs[k] = coefs[g*lutWidth + k];
        end

        if (g == 0) begin : gFirst
            partialSumLut #(
                .lutWidth(lutWidth)
            ) uLut (
                .clkDS(clkDS),
                .rst(rst),
                .inValid(frameStrobe),
                .sel(window[g*lutWidth +: lutWidth]),
                .coefs(groupCoefs),
                .sum(lutSums[g]),
                .outValid(lutValid)
            );
        end else begin : gRest
            // Valid of lookup 0 speaks for all of them
            partialSumLut #(
                .lutWidth(lutWidth)
            ) uLut (
                .clkDS(clkDS),
                .rst(rst),
                .inValid(frameStrobe),
                .sel(window[g*lutWidth +: lutWidth]),
                .coefs(groupCoefs),
                .sum(lutSums[g]),
                .outValid()
            );
        end
    end

    adderTree #(
        .numInputs(numLuts)
    ) uAdderTree (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(lutValid),
        .partials(lutSums),
        .result(outValue),
        .resultValid(outStrobe)
    );

endmodule

// ==== source/firPkg.sv ====
package firPkg;

    // Coefficient and accumulator widths
    localparam int coefWidth = 12;
    localparam int sumWidth = 20;

    // Caps numTaps at 256
    localparam int tapAddrWidth = 8;

    typedef logic signed [coefWidth-1:0] coefT;

    // Wide enough for 256 full-scale coefficients
    typedef logic signed [sumWidth-1:0] sumT;

    // One coefficient write as tap index plus value
    typedef struct packed {
        logic [tapAddrWidth-1:0] addr;
        coefT value;
    } coefWriteT;

endpackage

// ==== source/partialSumLut.sv ====
`timescale 1ns/1ps

module partialSumLut #(
    parameter int lutWidth = 4
) (
    input  logic                clkDS,
    input  logic                rst,
    input  logic                inValid,
    input  logic [lutWidth-1:0] sel,
    input  firPkg::coefT        coefs [lutWidth],
    output firPkg::sumT         sum,
    output logic                outValid
);
    import firPkg::*;

    sumT lutSum;

    // Sum of the coefficients whose window bit is set
    always_comb begin
        lutSum = '0;
        for (int i = 0; i < lutWidth; i++) begin
            if (sel[i]) begin
                lutSum = lutSum + sumT'(coefs[i]);
            end
        end
    end

    always_ff @(posedge clkDS) begin
        sum <= lutSum;
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

endmodule

// ==== source/sampleWindow.sv ====
`timescale 1ns/1ps

module sampleWindow #(
    parameter int numTaps = 32,
    parameter int osr = 8
) (
    input  logic               clkDS,
    input  logic               rst,
    input  logic               sampleStrobe,
    input  logic               sampleBit,
    output logic               frameStrobe,
    output logic [numTaps-1:0] window
);
    localparam int countWidth = (osr > 1) ? $clog2(osr) : 1;

    logic [numTaps-1:0]    shiftReg;
    logic [numTaps-1:0]    shiftNext;
    logic [countWidth-1:0] count;
    logic                  frameDone;

    // Newest bit enters at position 0
    assign shiftNext = (shiftReg << 1) | numTaps'(sampleBit);
    assign frameDone = sampleStrobe && (count == countWidth'(osr - 1));

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            shiftReg <= '0;
        end else if (sampleStrobe) begin
            shiftReg <= shiftNext;
        end
    end

    // Strobes counted modulo osr
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            count <= '0;
        end else if (frameDone) begin
            count <= '0;
        end else if (sampleStrobe) begin
            count <= count + 1'b1;
        end
    end

    // Frozen copy so later bits leave a frame in flight alone
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            window <= '0;
            frameStrobe <= 1'b0;
        end else begin
            frameStrobe <= frameDone;
            if (frameDone) begin
                window <= shiftNext;
            end
        end
    end

    if (osr > 1) begin : gFrameCheck
        // At least osr strobes between two frames
        singleCycleFrame: assert property (
            @(posedge clkDS) disable iff (!rst)
            frameStrobe |=> !frameStrobe
        ) else $error("sampleWindow: frameStrobe held for two cycles");
    end

endmodule
